//--- common/t08_disp_pkg.sv
/*
 * Touch and display package
 * Coordinate and bus byte types, display command bytes,
 * drawing colour, touch controller I2C constants
 */
package t08_disp_pkg;

    // One touch coordinate as reported by the panel
    typedef logic [11:0] coord_t;

    // Byte on the 8080 parallel display bus
    typedef logic [7:0] lcd_byte_t;

    // Display commands
    localparam lcd_byte_t CMD_SLPOUT = 8'h11;
    localparam lcd_byte_t CMD_DISPON = 8'h29;
    localparam lcd_byte_t CMD_CASET  = 8'h2A;
    localparam lcd_byte_t CMD_PASET  = 8'h2B;
    localparam lcd_byte_t CMD_RAMWR  = 8'h2C;

    // RGB565 red, high byte goes out first
    localparam logic [15:0] PIXEL_COLOR = 16'hF800;

    // Touch controller on I2C
    localparam logic [6:0] TOUCH_ADDR = 7'h38;
    // First coordinate register
    localparam lcd_byte_t TOUCH_REG = 8'h03;
    // Clock cycles per quarter SCL period
    localparam int unsigned I2C_QUARTER = 4;

    // dcx levels
    localparam logic LCD_CMD  = 1'b0;
    localparam logic LCD_DATA = 1'b1;

endpackage

//--- common/t08_wb_pkg.sv
/*
 * Wishbone package
 * Bus field types and log ring buffer constants
 */
package t08_wb_pkg;

    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Ring buffer in harness memory
    localparam wb_addr_t    LOG_BASE  = 32'h3000_0000;
    localparam int unsigned LOG_DEPTH = 8;

    // Ring entry index
    typedef logic [$clog2(LOG_DEPTH)-1:0] log_idx_t;

endpackage

//--- common/t08_lcd_byte_if.sv
/*
 * Display byte request interface
 * Draw controller to bus writer handshake
 */
`timescale 1ns/1ps

interface t08_lcd_byte_if import t08_disp_pkg::*; ();

    // One cycle strobe, only while busy is low
    logic      start;
    // Command or data select for this byte
    logic      dcx;
    lcd_byte_t data;
    // High from the cycle after start until the bus cycle ends
    logic      busy;

    modport ctrl (output start, output dcx, output data, input busy);

    modport writer (input start, input dcx, input data, output busy);

endinterface

//--- i2c/t08_i2c_touch.sv
/*
 * I2C touch reader
 * On a falling interrupt writes the start register, then reads
 * four coordinate bytes and pulses point_valid with x and y
 */
`timescale 1ns/1ps

module t08_i2c_touch import t08_disp_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   touch_int,
    input  logic   ctrl_busy,
    input  logic   sda_in,
    output logic   sda_low,
    output logic   scl_low,
    output logic   point_valid,
    output coord_t point_x,
    output coord_t point_y
);

    typedef enum logic [2:0] {
        S_IDLE, S_START, S_ADDR_W, S_REG, S_RSTART, S_ADDR_R, S_READ, S_STOP
    } i2c_state_t;

    i2c_state_t                       state;
    logic [$clog2(I2C_QUARTER)-1:0]   qcnt;
    // Quarter within the current bit slot
    logic [1:0]                       q;
    // 8 data bits plus the ACK slot
    logic [3:0]                       bit_cnt;
    logic [1:0]                       byte_cnt;
    // Two sync stages plus the previous value
    logic [2:0]                       int_sync;
    logic                             int_fall;
    logic                             tick;
    logic                             sda_drv;
    logic                             scl_drv;
    lcd_byte_t                        tx_byte;
    // xh, xl, yh, yl in arrival order
    logic [31:0]                      rx_sr;

    assign int_fall = int_sync[2] && !int_sync[1];
    assign tick     = (int'(qcnt) == I2C_QUARTER - 1);

    always_comb begin
        case (state)
            S_ADDR_W: tx_byte = {TOUCH_ADDR, 1'b0};
            S_ADDR_R: tx_byte = {TOUCH_ADDR, 1'b1};
            default:  tx_byte = TOUCH_REG;
        endcase
    end

    // Pin levels per quarter
    // SCL high in quarters 1 and 2 of a bit slot
    always_comb begin
        sda_drv = 1'b0;
        scl_drv = 1'b0;
        case (state)
            S_IDLE: begin
                sda_drv = 1'b0;
            end
            S_START, S_RSTART: begin
                // SDA falls in quarter 2 with SCL high
                sda_drv = q[1];
                scl_drv = (q == 2'd3) || (state == S_RSTART && q == 2'd0);
            end
            S_STOP: begin
                // SDA rises in quarter 2 with SCL high
                sda_drv = !q[1];
                scl_drv = (q == 2'd0);
            end
            default: begin
                scl_drv = (q == 2'd0) || (q == 2'd3);
                if (bit_cnt == 4'd8) begin
                    // ACK the first three read bytes, NACK the last
                    sda_drv = (state == S_READ) && (byte_cnt != 2'd3);
                end else if (state != S_READ) begin
                    sda_drv = !tx_byte[3'd7 - bit_cnt[2:0]];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_IDLE;
            qcnt        <= '0;
            q           <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            int_sync    <= '1;
            sda_low     <= 1'b0;
            scl_low     <= 1'b0;
            point_valid <= 1'b0;
        end else begin
            int_sync    <= {int_sync[1:0], touch_int};
            sda_low     <= sda_drv;
            scl_low     <= scl_drv;
            point_valid <= 1'b0;
            if (state == S_IDLE) begin
                qcnt <= '0;
                q    <= '0;
                // Touches during a busy draw are dropped
                if (int_fall && !ctrl_busy) begin
                    state <= S_START;
                end
            end else begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick) begin
                    q <= q + 1'b1;
                    // End of a bit slot
                    if (q == 2'd3) begin
                        case (state)
                            S_START:  state <= S_ADDR_W;
                            S_RSTART: state <= S_ADDR_R;
                            S_STOP: begin
                                state       <= S_IDLE;
                                point_valid <= 1'b1;
                            end
                            default: begin
                                if (bit_cnt == 4'd8) begin
                                    bit_cnt <= '0;
                                    case (state)
                                        S_ADDR_W: state <= S_REG;
                                        S_REG:    state <= S_RSTART;
                                        S_ADDR_R: state <= S_READ;
                                        default: begin
                                            // Wraps back to 0 for the next touch
                                            byte_cnt <= byte_cnt + 1'b1;
                                            if (byte_cnt == 2'd3) begin
                                                state <= S_STOP;
                                            end
                                        end
                                    endcase
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                end
                            end
                        endcase
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        // Sample in the middle of SCL high
        if (state == S_READ && bit_cnt < 4'd8 && tick && q == 2'd1) begin
            rx_sr <= {rx_sr[30:0], sda_in};
        end
        // Low nibble of each high byte plus the low byte
        if (state == S_STOP && tick && q == 2'd3) begin
            point_x <= {rx_sr[27:24], rx_sr[23:16]};
            point_y <= {rx_sr[11:8], rx_sr[7:0]};
        end
    end

    // SDA only moves under SCL high for start and stop
    assert property (@(posedge clk) disable iff (!arst_n)
        $changed(sda_low) |-> scl_low || (state inside {S_START, S_RSTART, S_STOP}))
        else $error("SDA changed while SCL high outside start or stop");

endmodule

//--- lcd/t08_lcd_writer.sv
/*
 * Display bus writer
 * One 8080 write cycle per requested byte
 */
`timescale 1ns/1ps

module t08_lcd_writer import t08_disp_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    t08_lcd_byte_if.writer req,
    output lcd_byte_t lcd_data,
    output logic      lcd_wrx,
    output logic      lcd_rdx,
    output logic      lcd_csx,
    output logic      lcd_dcx
);

    // Setup with csx low, wrx pulse low, wrx back high
    typedef enum logic [1:0] {W_IDLE, W_SETUP, W_LOW, W_HIGH} wr_state_t;

    wr_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE:  state <= req.start ? W_SETUP : W_IDLE;
                W_SETUP: state <= W_LOW;
                W_LOW:   state <= W_HIGH;
                default: state <= W_IDLE;
            endcase
        end
    end

    // Byte and dcx held for the whole cycle
    always_ff @(posedge clk) begin
        if (req.start) begin
            lcd_data <= req.data;
            lcd_dcx  <= req.dcx;
        end
    end

    assign req.busy = (state != W_IDLE);
    assign lcd_csx  = (state == W_IDLE);
    // Display latches on the rising edge of wrx
    assign lcd_wrx  = (state != W_LOW);
    // No reads from the display
    assign lcd_rdx  = 1'b1;

    // Controller must wait for busy low
    assert property (@(posedge clk) disable iff (!arst_n) req.start |-> !req.busy)
        else $error("Display byte requested while writer busy");

endmodule

//--- hw/t08_draw_ctrl.sv
/*
 * Draw controller
 * Display init, then per touch a log request and
 * the column, page and memory write sequence for one pixel
 */
`timescale 1ns/1ps

module t08_draw_ctrl import t08_disp_pkg::*, t08_wb_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    t08_lcd_byte_if.ctrl req,
    input  logic     point_valid,
    input  coord_t   point_x,
    input  coord_t   point_y,
    output logic     ctrl_busy,
    output logic     log_req,
    output wb_data_t log_data,
    input  logic     log_busy
);

    typedef enum logic [1:0] {D_SEND, D_DONE, D_IDLE} draw_state_t;

    draw_state_t state;
    // Index into the byte sequence
    logic [3:0]  cnt;
    // {dcx, byte} for the current index
    logic [8:0]  cur;

    // Entries 0 and 1 are init, 2 to 14 draw one pixel
    function automatic logic [8:0] seq_byte(input logic [3:0] idx, input coord_t x,
                                            input coord_t y);
        lcd_byte_t xh;
        lcd_byte_t yh;
        xh = {4'h0, x[11:8]};
        yh = {4'h0, y[11:8]};
        case (idx)
            4'd0:         seq_byte = {LCD_CMD, CMD_SLPOUT};
            4'd1:         seq_byte = {LCD_CMD, CMD_DISPON};
            4'd2:         seq_byte = {LCD_CMD, CMD_CASET};
            // Start and end column are the same
            4'd3, 4'd5:   seq_byte = {LCD_DATA, xh};
            4'd4, 4'd6:   seq_byte = {LCD_DATA, x[7:0]};
            4'd7:         seq_byte = {LCD_CMD, CMD_PASET};
            4'd8, 4'd10:  seq_byte = {LCD_DATA, yh};
            4'd9, 4'd11:  seq_byte = {LCD_DATA, y[7:0]};
            4'd12:        seq_byte = {LCD_CMD, CMD_RAMWR};
            4'd13:        seq_byte = {LCD_DATA, PIXEL_COLOR[15:8]};
            default:      seq_byte = {LCD_DATA, PIXEL_COLOR[7:0]};
        endcase
    endfunction

    assign cur       = seq_byte(cnt, point_x, point_y);
    assign req.start = (state == D_SEND) && !req.busy;
    assign req.dcx   = cur[8];
    assign req.data  = cur[7:0];
    assign ctrl_busy = (state != D_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Init starts straight out of reset
            state   <= D_SEND;
            cnt     <= '0;
            log_req <= 1'b0;
        end else begin
            log_req <= 1'b0;
            case (state)
                D_SEND: begin
                    if (!req.busy) begin
                        // Last init byte or last pixel byte
                        if (cnt == 4'd1 || cnt == 4'd14) begin
                            state <= D_DONE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                D_DONE: begin
                    // Last byte out and log write acked
                    if (!req.busy && !log_busy) begin
                        state <= D_IDLE;
                    end
                end
                default: begin
                    if (point_valid) begin
                        state   <= D_SEND;
                        cnt     <= 4'd2;
                        log_req <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Log word {y, x}, each zero extended to 16 bits
    always_ff @(posedge clk) begin
        if (point_valid && state == D_IDLE) begin
            log_data <= {4'h0, point_y, 4'h0, point_x};
        end
    end

endmodule

//--- hw/t08_wb_log.sv
/*
 * Wishbone log master
 * Single word writes into a ring buffer in harness memory
 */
`timescale 1ns/1ps

module t08_wb_log import t08_wb_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     log_req,
    input  wb_data_t log_data,
    output logic     log_busy,
    output wb_addr_t wb_adr,
    output wb_data_t wb_dat_o,
    output wb_sel_t  wb_sel,
    output logic     wb_we,
    output logic     wb_stb,
    output logic     wb_cyc,
    input  wb_data_t wb_dat_i,
    input  logic     wb_ack
);

    log_idx_t idx;

    // Cycle held until the slave acks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_cyc <= 1'b0;
            idx    <= '0;
        end else if (!wb_cyc && log_req) begin
            wb_cyc <= 1'b1;
        end else if (wb_cyc && wb_ack) begin
            wb_cyc <= 1'b0;
            idx    <= (idx == log_idx_t'(LOG_DEPTH - 1)) ? '0 : idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!wb_cyc && log_req) begin
            wb_dat_o <= log_data;
        end
    end

    // One word per entry
    assign wb_adr   = LOG_BASE + wb_addr_t'({idx, 2'b00});
    assign wb_sel   = '1;
    assign wb_we    = wb_cyc;
    assign wb_stb   = wb_cyc;
    assign log_busy = wb_cyc;
    // Write only master, wb_dat_i has no use here

    // Strobe may only drop on an ack
    assert property (@(posedge clk) disable iff (!arst_n)
        wb_cyc && wb_stb && !wb_ack |=> wb_stb)
        else $error("Wishbone strobe dropped without ack");

endmodule

//--- hw/t08_top.sv
/*
 * Inner top
 * Reset synchronizer, open drain I2C pins,
 * touch reader, draw controller, display writer, log master
 */
`timescale 1ns/1ps

module t08_top import t08_disp_pkg::*, t08_wb_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      touch_int,
    input  logic      sda_in,
    output logic      sda_out,
    output logic      sda_oeb,
    output logic      scl_out,
    output logic      scl_oeb,
    output lcd_byte_t lcd_data,
    output logic      lcd_wrx,
    output logic      lcd_rdx,
    output logic      lcd_csx,
    output logic      lcd_dcx,
    output wb_addr_t  adr,
    output wb_data_t  dat_o,
    output wb_sel_t   sel,
    output logic      we,
    output logic      stb,
    output logic      cyc,
    input  wb_data_t  dat_i,
    input  logic      ack
);

    logic [1:0] rst_sync;
    logic       rst_n;
    logic       sda_low;
    logic       scl_low;
    logic       point_valid;
    coord_t     point_x;
    coord_t     point_y;
    logic       ctrl_busy;
    logic       log_req;
    wb_data_t   log_data;
    logic       log_busy;

    t08_lcd_byte_if lcd_req ();

    // Asserts at once, releases on the second edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync <= '0;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rst_n = rst_sync[1];

    // Open drain pins
    // Output stays 0, enable only while pulling low
    assign sda_out = 1'b0;
    assign scl_out = 1'b0;
    assign sda_oeb = !sda_low;
    assign scl_oeb = !scl_low;

    t08_i2c_touch i2c_i (
        .clk         (clk),
        .arst_n      (rst_n),
        .touch_int   (touch_int),
        .ctrl_busy   (ctrl_busy),
        .sda_in      (sda_in),
        .sda_low     (sda_low),
        .scl_low     (scl_low),
        .point_valid (point_valid),
        .point_x     (point_x),
        .point_y     (point_y)
    );

    t08_draw_ctrl draw_i (
        .clk         (clk),
        .arst_n      (rst_n),
        .req         (lcd_req.ctrl),
        .point_valid (point_valid),
        .point_x     (point_x),
        .point_y     (point_y),
        .ctrl_busy   (ctrl_busy),
        .log_req     (log_req),
        .log_data    (log_data),
        .log_busy    (log_busy)
    );

    t08_lcd_writer lcd_i (
        .clk      (clk),
        .arst_n   (rst_n),
        .req      (lcd_req.writer),
        .lcd_data (lcd_data),
        .lcd_wrx  (lcd_wrx),
        .lcd_rdx  (lcd_rdx),
        .lcd_csx  (lcd_csx),
        .lcd_dcx  (lcd_dcx)
    );

    t08_wb_log log_i (
        .clk      (clk),
        .arst_n   (rst_n),
        .log_req  (log_req),
        .log_data (log_data),
        .log_busy (log_busy),
        .wb_adr   (adr),
        .wb_dat_o (dat_o),
        .wb_sel   (sel),
        .wb_we    (we),
        .wb_stb   (stb),
        .wb_cyc   (cyc),
        .wb_dat_i (dat_i),
        .wb_ack   (ack)
    );

endmodule

//--- hw/team_08.sv
/*
 * Harness wrapper
 * GPIO pin map, fixed output enables, enable gated reset
 */
`timescale 1ns/1ps

module team_08 import t08_wb_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        en,
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb,
    output wb_addr_t    adr,
    output wb_data_t    dat_o,
    output wb_sel_t     sel,
    output logic        we,
    output logic        stb,
    output logic        cyc,
    input  wb_data_t    dat_i,
    input  logic        ack
);

    // Pin 0 touch interrupt, 15 to 33 unused, all inputs
    assign gpio_oeb[33:15] = '1;
    assign gpio_oeb[0]     = 1'b1;
    // Display bus pins 3 to 14 always driven
    assign gpio_oeb[14:3]  = '0;

    // Unused outputs tied low
    assign gpio_out[33:15] = '0;
    assign gpio_out[0]     = 1'b0;

    // Chip held in reset while disabled
    t08_top top_i (
        .clk       (clk),
        .arst_n    (arst_n & en),
        .touch_int (gpio_in[0]),
        .sda_in    (gpio_in[1]),
        .sda_out   (gpio_out[1]),
        .sda_oeb   (gpio_oeb[1]),
        .scl_out   (gpio_out[2]),
        .scl_oeb   (gpio_oeb[2]),
        .lcd_data  (gpio_out[10:3]),
        .lcd_wrx   (gpio_out[11]),
        .lcd_rdx   (gpio_out[12]),
        .lcd_csx   (gpio_out[13]),
        .lcd_dcx   (gpio_out[14]),
        .adr       (adr),
        .dat_o     (dat_o),
        .sel       (sel),
        .we        (we),
        .stb       (stb),
        .cyc       (cyc),
        .dat_i     (dat_i),
        .ack       (ack)
    );

endmodule

//--- testbench/tb_touch_model.sv
/*
 * Touch controller model
 * I2C slave that serves one four byte coordinate read per interrupt
 * and checks the transfer framing
 */
`timescale 1ns/1ps

module tb_touch_model (
    input  logic        clk,
    input  logic        touch_req,
    input  logic [15:0] x_raw,
    input  logic [15:0] y_raw,
    inout  wire         sda,
    input  wire         scl,
    output logic        touch_int,
    output logic        proto_err
);

    logic sda_pull;
    int   scl_rises;

    // Open drain, the pull-up sits on the net
    assign sda = sda_pull ? 1'b0 : 1'bz;

    always @(posedge scl) begin
        scl_rises++;
    end

    task automatic flag_error(input string msg);
        $display("FAIL t=%0t: %s", $time, msg);
        proto_err = 1'b1;
    endtask

    // Start or repeated start, SDA falling with SCL high
    task automatic wait_start();
        do begin
            @(negedge sda);
        end while (scl !== 1'b1);
    endtask

    task automatic recv_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            @(posedge scl);
            b = {b[6:0], sda};
        end
    endtask

    // Pull low for the ACK slot, left low until released
    task automatic give_ack();
        @(negedge scl);
        sda_pull = 1'b1;
        @(posedge scl);
    endtask

    task automatic release_at_fall();
        @(negedge scl);
        sda_pull = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            @(negedge scl);
            sda_pull = !b[7-i];
            @(posedge scl);
        end
    endtask

    task automatic serve_read();
        logic [7:0]  b;
        logic [31:0] coords;
        int          rises;
        coords = {x_raw, y_raw};
        wait_start();
        recv_byte(b);
        assert (b == 8'h70) else flag_error($sformatf("address write byte %02h", b));
        give_ack();
        release_at_fall();
        recv_byte(b);
        assert (b == 8'h03) else flag_error($sformatf("register byte %02h", b));
        give_ack();
        release_at_fall();
        rises = scl_rises;
        wait_start();
        assert (scl_rises - rises == 1) else flag_error("repeated start missing");
        recv_byte(b);
        assert (b == 8'h71) else flag_error($sformatf("address read byte %02h", b));
        give_ack();
        for (int n = 0; n < 4; n++) begin
            send_byte(coords[31-8*n -: 8]);
            release_at_fall();
            @(posedge scl);
            // Master ACKs three bytes, NACKs the last
            assert (sda === (n == 3)) else flag_error($sformatf("master ack byte %0d", n));
        end
        @(posedge sda);
        assert (scl === 1'b1) else flag_error("stop condition missing after NACK");
    endtask

    initial begin
        touch_int = 1'b1;
        sda_pull  = 1'b0;
        proto_err = 1'b0;
        scl_rises = 0;
        forever begin
            @(posedge clk);
            if (touch_req) begin
                touch_int <= 1'b0;
                serve_read();
                @(posedge clk);
                touch_int <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_team_08.sv
/*
 * Testbench for team_08
 * Clock, reset, touch stimulus, Wishbone slave,
 * display bus monitor, assertions, watchdog
 */
`timescale 1ns/1ps

module tb_team_08 import t08_disp_pkg::*, t08_wb_pkg::*; ();

    localparam int     N_TOUCH     = 6;
    localparam time    CLK_PERIOD  = 40;
    // About 1600 cycles per touch plus init and enable toggle
    localparam time    WATCHDOG_NS = (N_TOUCH * 1600 + 400) * CLK_PERIOD;
    localparam [33:0]  OEB_FIXED   = 34'h3_FFFF_8001;
    // I2C enables on bits 1 and 2 move
    localparam [33:0]  OEB_MASK    = 34'h3_FFFF_FFF9;

    logic        clk;
    logic        arst_n;
    logic        en;
    logic [33:3] gpio_rest;
    wire  [33:0] gpio_in;
    wire  [33:0] gpio_out;
    wire  [33:0] gpio_oeb;
    wb_addr_t    adr;
    wb_data_t    dat_o;
    wb_sel_t     sel;
    logic        we;
    logic        stb;
    logic        cyc;
    wb_data_t    dat_i;
    logic        ack;
    tri1         sda;
    tri1         scl;
    wire         touch_int;
    wire         proto_err;
    logic        touch_req;
    logic [15:0] x_raw;
    logic [15:0] y_raw;
    logic [15:0] lfsr;
    logic [8:0]  exp_q[$];
    wb_data_t    log_q[$];
    int          ack_delay[N_TOUCH];
    int          wait_left;
    int          wb_count;

    assign sda     = gpio_oeb[1] ? 1'bz : gpio_out[1];
    assign scl     = gpio_oeb[2] ? 1'bz : gpio_out[2];
    assign gpio_in = {gpio_rest, scl, sda, touch_int};

    team_08 team_08_i (
        .clk (clk), .arst_n (arst_n), .en (en),
        .gpio_in (gpio_in), .gpio_out (gpio_out), .gpio_oeb (gpio_oeb),
        .adr (adr), .dat_o (dat_o), .sel (sel), .we (we), .stb (stb), .cyc (cyc),
        .dat_i (dat_i), .ack (ack)
    );

    tb_touch_model touch_i (
        .clk (clk), .touch_req (touch_req), .x_raw (x_raw), .y_raw (y_raw),
        .sda (sda), .scl (scl), .touch_int (touch_int), .proto_err (proto_err)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // Fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Column, page and memory write bytes for one pixel
    task automatic expect_point(input coord_t x, input coord_t y);
        exp_q.push_back({LCD_CMD, CMD_CASET});
        repeat (2) begin
            exp_q.push_back({LCD_DATA, 4'h0, x[11:8]});
            exp_q.push_back({LCD_DATA, x[7:0]});
        end
        exp_q.push_back({LCD_CMD, CMD_PASET});
        repeat (2) begin
            exp_q.push_back({LCD_DATA, 4'h0, y[11:8]});
            exp_q.push_back({LCD_DATA, y[7:0]});
        end
        exp_q.push_back({LCD_CMD, CMD_RAMWR});
        exp_q.push_back({LCD_DATA, PIXEL_COLOR[15:8]});
        exp_q.push_back({LCD_DATA, PIXEL_COLOR[7:0]});
        log_q.push_back({4'h0, y, 4'h0, x});
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || log_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the touch sequence completed");
    end

    initial begin
        wait (proto_err);
        abort_run("Touch model reported an I2C protocol error");
    end

    // Byte latched by the display on rising wrx
    always @(posedge gpio_out[11]) begin
        if (gpio_out[13] === 1'b0) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("FAIL t=%0t: unexpected display byte %02h",
                                    $time, gpio_out[10:3]));
            end else begin
                assert ({gpio_out[14], gpio_out[10:3]} == exp_q[0])
                    else abort_run($sformatf("FAIL t=%0t: display got %03h want %03h",
                                             $time, {gpio_out[14], gpio_out[10:3]}, exp_q[0]));
                void'(exp_q.pop_front());
            end
        end
    end

    // Slave with random ack latency
    always @(posedge clk) begin
        ack <= 1'b0;
        if (cyc && stb && !ack) begin
            if (wait_left == 0) begin
                assert (log_q.size() != 0 && dat_o == log_q[0])
                    else abort_run($sformatf("FAIL t=%0t: log data %08h", $time, dat_o));
                assert (adr == LOG_BASE + 4 * (wb_count % LOG_DEPTH))
                    else abort_run($sformatf("FAIL t=%0t: log address %08h", $time, adr));
                assert (sel == 4'hF && we)
                    else abort_run($sformatf("FAIL t=%0t: sel %h we %b", $time, sel, we));
                void'(log_q.pop_front());
                ack       <= 1'b1;
                wb_count  = wb_count + 1;
                wait_left = ack_delay[wb_count % N_TOUCH];
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    assert property (@(posedge clk) (gpio_oeb & OEB_MASK) == OEB_FIXED)
        else abort_run($sformatf("FAIL t=%0t: gpio_oeb %09h", $time, gpio_oeb));

    // Unused pins stay low and rdx stays high
    assert property (@(posedge clk) gpio_out[12] && gpio_out[33:15] == '0 && !gpio_out[0])
        else abort_run($sformatf("FAIL t=%0t: gpio_out %09h", $time, gpio_out));

    assert property (@(posedge clk) disable iff (!arst_n || !en) cyc && !ack |=> cyc && stb)
        else abort_run($sformatf("FAIL t=%0t: Wishbone cycle dropped before ack", $time));

    // Held in reset while disabled
    assert property (@(posedge clk) !en |-> gpio_out[13] && gpio_out[11] && gpio_out[12]
                     && !cyc && gpio_oeb[1] && gpio_oeb[2])
        else abort_run($sformatf("FAIL t=%0t: outputs active while en low", $time));

    initial begin
        logic [15:0] d;
        arst_n    = 1'b0;
        en        = 1'b1;
        gpio_rest = '0;
        dat_i     = '0;
        ack       = 1'b0;
        touch_req = 1'b0;
        x_raw     = '0;
        y_raw     = '0;
        wb_count  = 0;
        lfsr      = 16'd56816;
        for (int i = 0; i < N_TOUCH; i++) begin
            take_bits(2, d);
            ack_delay[i] = d;
        end
        wait_left = ack_delay[0];
        exp_q.push_back({LCD_CMD, CMD_SLPOUT});
        exp_q.push_back({LCD_CMD, CMD_DISPON});
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait_drained();
        for (int t = 0; t < N_TOUCH; t++) begin
            repeat (20) @(posedge clk);
            take_bits(16, x_raw);
            take_bits(16, y_raw);
            expect_point(x_raw[11:0], y_raw[11:0]);
            touch_req <= 1'b1;
            @(posedge clk);
            touch_req <= 1'b0;
            wait_drained();
        end
        repeat (20) @(posedge clk);
        // Touch cut short by en while the master holds SCL low
        touch_req <= 1'b1;
        @(posedge clk);
        touch_req <= 1'b0;
        while (gpio_oeb[2] !== 1'b0) begin
            @(posedge clk);
        end
        en <= 1'b0;
        repeat (10) @(posedge clk);
        exp_q.push_back({LCD_CMD, CMD_SLPOUT});
        exp_q.push_back({LCD_CMD, CMD_DISPON});
        en <= 1'b1;
        wait_drained();
        repeat (5) @(posedge clk);
        if (!proto_err) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Touch model error at end of run");
        end
    end

endmodule

//--- verilog.f
common/t08_disp_pkg.sv
common/t08_wb_pkg.sv
common/t08_lcd_byte_if.sv
i2c/t08_i2c_touch.sv
lcd/t08_lcd_writer.sv
hw/t08_draw_ctrl.sv
hw/t08_wb_log.sv
hw/t08_top.sv
hw/team_08.sv
testbench/tb_touch_model.sv
testbench/tb_team_08.sv

//--- Bender.yml
package:
  name: team_08

sources:
  - files:
      - common/t08_disp_pkg.sv
      - common/t08_wb_pkg.sv
      - common/t08_lcd_byte_if.sv
      - i2c/t08_i2c_touch.sv
      - lcd/t08_lcd_writer.sv
      - hw/t08_draw_ctrl.sv
      - hw/t08_wb_log.sv
      - hw/t08_top.sv
      - hw/team_08.sv
  - target: test
    files:
      - testbench/tb_touch_model.sv
      - testbench/tb_team_08.sv
